/* hw/cpu_pkg.sv */
package cpu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [10:0] disk_addr_t;

    typedef enum logic {
        phase_fetch,
        phase_exec
    } phase_t;

    typedef enum logic [2:0] {
        wb_alu, wb_shift, wb_mem, wb_link, wb_epc
    } wb_sel_t;

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_lui
    } alu_op_t;

    // Decoded control, 19 bits
    typedef struct packed {
        logic     gp_we;
        logic     mem_rren;
        logic     mem_wren;
        alu_op_t  alu_op;
        logic     shift_right;  // 0 sll, 1 srl
        logic     imm_sel;      // B operand from immediate
        logic     trap_ovf;
        wb_sel_t  wb_sel;
        reg_idx_t dest;
        logic     eret;
        logic     illegal;
    } ctrl_t;

    // One master's view of the shared bus
    typedef struct packed {
        addr_t addr;
        word_t wdata;
        logic  rreq;
        logic  wreq;
    } bus_req_t;

    localparam addr_t    trap_vector = 32'h0000_0100;
    localparam addr_t    disk_base   = 32'h8000_0000;
    localparam reg_idx_t debug_reg   = 5'd2;

    localparam logic [5:0] op_special = 6'h00;
    localparam logic [5:0] op_j       = 6'h02;
    localparam logic [5:0] op_beq     = 6'h04;
    localparam logic [5:0] op_bne     = 6'h05;
    localparam logic [5:0] op_addi    = 6'h08;
    localparam logic [5:0] op_addiu   = 6'h09;
    localparam logic [5:0] op_ori     = 6'h0d;
    localparam logic [5:0] op_lui     = 6'h0f;
    localparam logic [5:0] op_cop0    = 6'h10;
    localparam logic [5:0] op_lw      = 6'h23;
    localparam logic [5:0] op_sw      = 6'h2b;

    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_eret = 6'h18;
    localparam logic [5:0] fn_add  = 6'h20;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_slt  = 6'h2a;

endpackage

/* hw/cpu_gpr.sv */
`timescale 1ns/100ps

module cpu_gpr import cpu_pkg::*; (
    input  logic     E,
    input  logic     jisr,
    input  logic     we,
    input  reg_idx_t rs,
    input  reg_idx_t rt,
    input  reg_idx_t wa,
    input  word_t    wd,
    output word_t    rd1,
    output word_t    rd2,
    output word_t    register_out
);

    word_t regs [32];

    always_ff @(posedge E or posedge jisr) begin
        if (jisr) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (we && wa != 5'd0) begin  // r0 never written
            regs[wa] <= wd;
        end
    end

    assign rd1          = regs[rs];
    assign rd2          = regs[rt];
    assign register_out = regs[debug_reg];

endmodule

/* hw/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter import cpu_pkg::*; (
    input  phase_t      phase,
    input  bus_req_t    fetch_req,
    input  bus_req_t    data_req,
    output word_t       rdata,
    // Main memory
    output logic [26:0] lpddr2_address,
    output word_t       lpddr2_write_data,
    input  word_t       lpddr2_read_data,
    output logic        lpddr2_rreq,
    output logic        lpddr2_wreq,
    // Disk buffer
    output word_t       disk_hdin,
    input  word_t       disk_hdout,
    output disk_addr_t  disk_hda,
    output logic        disk_hd_w
);

    bus_req_t grant;
    logic     to_disk;

    // Phase decides the master, address decides the target
    assign grant   = (phase == phase_fetch) ? fetch_req : data_req;
    assign to_disk = grant.addr >= disk_base;

    assign lpddr2_address    = grant.addr[28:2];
    assign lpddr2_write_data = grant.wdata;
    assign lpddr2_rreq       = grant.rreq & ~to_disk;
    assign lpddr2_wreq       = grant.wreq & ~to_disk;

    assign disk_hda  = grant.addr[12:2];
    assign disk_hdin = grant.wdata;
    assign disk_hd_w = grant.wreq & to_disk;

    assign rdata = to_disk ? disk_hdout : lpddr2_read_data;

endmodule

/* hw/cpu_sequencer.sv */
`timescale 1ns/100ps

module cpu_sequencer import cpu_pkg::*; (
    input  logic     E,
    input  logic     jisr,
    input  logic     ena,
    input  ctrl_t    ctrl,
    input  addr_t    next_pc,
    input  logic     overflow,
    input  word_t    fetch_data,
    output phase_t   phase,
    output addr_t    pc,
    output word_t    instruction,
    output word_t    epc,
    output bus_req_t fetch_req
);

    logic  trap;
    addr_t pc_plus4;

    assign trap     = ctrl.illegal | overflow;
    assign pc_plus4 = pc + 32'd4;

    // Instruction fetch always reads at the PC
    assign fetch_req = '{addr:  pc,
                         wdata: '0,
                         rreq:  ena & (phase == phase_fetch),
                         wreq:  1'b0};

    always_ff @(posedge E or posedge jisr) begin
        if (jisr) begin
            phase <= phase_fetch;
            pc    <= '0;
            epc   <= '0;
        end else if (ena) begin
            if (phase == phase_fetch) begin
                phase <= phase_exec;
            end else begin
                phase <= phase_fetch;
                if (trap) begin
                    epc <= pc_plus4;  // Resume after the faulting word
                    pc  <= trap_vector;
                end else if (ctrl.eret) begin
                    pc <= epc;
                end else begin
                    pc <= next_pc;
                end
            end
        end
    end

    // IR loads once per instruction
    always_ff @(posedge E or posedge jisr) begin
        if (jisr)
            instruction <= '0;
        else if (ena && phase == phase_fetch)
            instruction <= fetch_data;
    end

endmodule

/* hw/cpu_decode.sv */
`timescale 1ns/100ps

module cpu_decode import cpu_pkg::*; (
    input  word_t    instruction,
    input  addr_t    pc,
    input  word_t    a_data,
    input  word_t    b_data,
    output ctrl_t    ctrl,
    output reg_idx_t rs,
    output reg_idx_t rt,
    output word_t    imm,
    output addr_t    next_pc
);

    logic [5:0] opcode, funct;
    reg_idx_t   rd;
    addr_t      pc_plus4, br_target;

    assign opcode    = instruction[31:26];
    assign funct     = instruction[5:0];
    assign rs        = instruction[25:21];
    assign rt        = instruction[20:16];
    assign rd        = instruction[15:11];
    assign pc_plus4  = pc + 32'd4;
    assign br_target = pc_plus4 + {imm[29:0], 2'b00};

    // ori takes its immediate unsigned, everything else sign extends
    assign imm = (opcode == op_ori) ? {16'h0, instruction[15:0]}
                                    : {{16{instruction[15]}}, instruction[15:0]};

    always_comb begin
        next_pc = pc_plus4;
        case (opcode)
            op_beq: if (a_data == b_data) next_pc = br_target;
            op_bne: if (a_data != b_data) next_pc = br_target;
            op_j:   next_pc = {pc_plus4[31:28], instruction[25:0], 2'b00};
            default: ;
        endcase
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = alu_add;
        ctrl.wb_sel = wb_alu;
        ctrl.dest   = rt;  // I-type writes rt
        case (opcode)
            op_special: begin
                ctrl.gp_we = 1'b1;
                ctrl.dest  = rd;
                case (funct)
                    fn_add:  ctrl.trap_ovf = 1'b1;
                    fn_addu: ;
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_slt:  ctrl.alu_op = alu_slt;
                    fn_sll:  ctrl.wb_sel = wb_shift;
                    fn_srl: begin
                        ctrl.wb_sel      = wb_shift;
                        ctrl.shift_right = 1'b1;
                    end
                    default: begin
                        ctrl.gp_we   = 1'b0;
                        ctrl.illegal = 1'b1;
                    end
                endcase
            end
            op_addi: begin
                ctrl.gp_we    = 1'b1;
                ctrl.imm_sel  = 1'b1;
                ctrl.trap_ovf = 1'b1;
            end
            op_addiu: begin
                ctrl.gp_we   = 1'b1;
                ctrl.imm_sel = 1'b1;
            end
            op_ori: begin
                ctrl.gp_we   = 1'b1;
                ctrl.imm_sel = 1'b1;
                ctrl.alu_op  = alu_or;
            end
            op_lui: begin
                ctrl.gp_we  = 1'b1;
                ctrl.alu_op = alu_lui;
            end
            op_lw: begin
                ctrl.gp_we    = 1'b1;
                ctrl.mem_rren = 1'b1;
                ctrl.wb_sel   = wb_mem;
            end
            op_sw:  ctrl.mem_wren = 1'b1;
            op_beq, op_bne, op_j: ;  // PC only
            op_cop0: begin
                if (rs == 5'd0) begin  // mfc0 reads the EPC
                    ctrl.gp_we  = 1'b1;
                    ctrl.wb_sel = wb_epc;
                end else if (instruction[25] && funct == fn_eret) begin
                    ctrl.eret = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

/* hw/cpu_execute.sv */
`timescale 1ns/100ps

module cpu_execute import cpu_pkg::*; (
    input  ctrl_t    ctrl,
    input  word_t    a_data,
    input  word_t    b_data,
    input  word_t    imm,
    input  addr_t    pc,
    input  word_t    epc,
    input  word_t    mem_rdata,
    input  phase_t   phase,
    output bus_req_t data_req,
    output word_t    wb_data,
    output logic     overflow
);

    word_t      b_op, alu_res, shift_res;
    addr_t      ea;
    logic [4:0] shamt;
    logic       go;

    assign b_op  = ctrl.imm_sel ? imm : b_data;
    assign shamt = imm[10:6];  // R-type shamt sits inside the low immediate
    assign ea    = a_data + imm;

    always_comb begin
        case (ctrl.alu_op)
            alu_sub: alu_res = a_data - b_op;
            alu_and: alu_res = a_data & b_op;
            alu_or:  alu_res = a_data | b_op;
            alu_slt: alu_res = {31'h0, $signed(a_data) < $signed(b_op)};
            alu_lui: alu_res = {imm[15:0], 16'h0};
            default: alu_res = a_data + b_op;
        endcase
    end

    assign shift_res = ctrl.shift_right ? (b_data >> shamt) : (b_data << shamt);

    // Same operand signs, different result sign
    assign overflow = ctrl.trap_ovf & (a_data[31] == b_op[31]) & (alu_res[31] != a_data[31]);

    always_comb begin
        case (ctrl.wb_sel)
            wb_shift: wb_data = shift_res;
            wb_mem:   wb_data = mem_rdata;
            wb_link:  wb_data = pc + 32'd4;
            wb_epc:   wb_data = epc;
            default:  wb_data = alu_res;
        endcase
    end

    assign go       = (phase == phase_exec) & ~ctrl.illegal & ~overflow;
    assign data_req = '{addr:  ea,
                        wdata: b_data,
                        rreq:  go & ctrl.mem_rren,
                        wreq:  go & ctrl.mem_wren};

endmodule

/* hw/cpu_master.sv */
`timescale 1ns/100ps

module cpu_master import cpu_pkg::*; (
    input  logic       E,
    input  logic       jisr,
    input  logic       ena,
    // Main memory
    output logic [26:0] lpddr2_address,
    output word_t       lpddr2_write_data,
    input  word_t       lpddr2_read_data,
    output logic        lpddr2_rreq,
    output logic        lpddr2_wreq,
    // Disk buffer
    output word_t       disk_hdin,
    input  word_t       disk_hdout,
    output disk_addr_t  disk_hda,
    output logic        disk_hd_w,
    output word_t       debug_hex_display
);

    phase_t   phase;
    addr_t    pc, next_pc;
    word_t    instruction, epc, imm;
    word_t    a_data, b_data, wb_data, rdata;
    ctrl_t    ctrl;
    reg_idx_t rs, rt;
    logic     overflow;
    logic     gpr_we;
    bus_req_t fetch_req, data_req, data_req_en;

    // Register write only at the end of a clean, enabled execute cycle
    assign gpr_we = ctrl.gp_we & (phase == phase_exec) & ~ctrl.illegal & ~overflow & ena;

    // Hold the data strobes off while the core is stalled
    assign data_req_en = '{addr:  data_req.addr,
                           wdata: data_req.wdata,
                           rreq:  data_req.rreq & ena,
                           wreq:  data_req.wreq & ena};

    cpu_sequencer u_seq (
        .E(E), .jisr(jisr), .ena(ena),
        .ctrl(ctrl), .next_pc(next_pc), .overflow(overflow),
        .fetch_data(rdata), .phase(phase), .pc(pc),
        .instruction(instruction), .epc(epc), .fetch_req(fetch_req)
    );

    cpu_decode u_dec (
        .instruction(instruction), .pc(pc), .a_data(a_data), .b_data(b_data),
        .ctrl(ctrl), .rs(rs), .rt(rt), .imm(imm), .next_pc(next_pc)
    );

    cpu_execute u_exe (
        .ctrl(ctrl), .a_data(a_data), .b_data(b_data), .imm(imm), .pc(pc),
        .epc(epc), .mem_rdata(rdata), .phase(phase),
        .data_req(data_req), .wb_data(wb_data), .overflow(overflow)
    );

    cpu_gpr u_gpr (
        .E(E), .jisr(jisr), .we(gpr_we), .rs(rs), .rt(rt), .wa(ctrl.dest),
        .wd(wb_data), .rd1(a_data), .rd2(b_data), .register_out(debug_hex_display)
    );

    mem_arbiter u_arb (
        .phase(phase), .fetch_req(fetch_req), .data_req(data_req_en), .rdata(rdata),
        .lpddr2_address(lpddr2_address), .lpddr2_write_data(lpddr2_write_data),
        .lpddr2_read_data(lpddr2_read_data), .lpddr2_rreq(lpddr2_rreq),
        .lpddr2_wreq(lpddr2_wreq), .disk_hdin(disk_hdin), .disk_hdout(disk_hdout),
        .disk_hda(disk_hda), .disk_hd_w(disk_hd_w)
    );

endmodule

/* tb/cpu_master_sva.sv */
`timescale 1ns/100ps

module cpu_master_sva import cpu_pkg::*; (
    input logic     E,
    input logic     jisr,
    input logic     ena,
    input phase_t   phase,
    input bus_req_t fetch_req,
    input bus_req_t data_req,
    input logic     lpddr2_rreq,
    input logic     lpddr2_wreq,
    input logic     disk_hd_w
);

    int failures = 0;  // Failed assertions so far

    // Fetch and execute take turns on every enabled edge
    phase_alternates: assert property (@(posedge E) disable iff (jisr)
        ena |=> phase != $past(phase))
        else begin
            failures++;
            $error("phase did not alternate on an enabled cycle");
        end

    phase_holds: assert property (@(posedge E) disable iff (jisr)
        !ena |=> phase == $past(phase))
        else begin
            failures++;
            $error("phase moved while the core was held");
        end

    one_master: assert property (@(posedge E)
        !((fetch_req.rreq | fetch_req.wreq) && (data_req.rreq | data_req.wreq)))
        else begin
            failures++;
            $error("fetch and data requests active in the same cycle");
        end

    quiet_when_held: assert property (@(posedge E) disable iff (jisr)
        !ena |-> !(lpddr2_rreq | lpddr2_wreq | disk_hd_w))
        else begin
            failures++;
            $error("bus strobe raised while the core was held");
        end

    reset_state: assert property (@(posedge E)
        jisr |-> phase == phase_fetch && !lpddr2_wreq && !disk_hd_w)
        else begin
            failures++;
            $error("wrong phase or write strobe during reset");
        end

endmodule

/* tb/cpu_master_tb.sv */
`timescale 1ns/100ps

module cpu_master_tb import cpu_pkg::*; ();

    logic        E;
    logic        jisr;
    logic        ena;
    logic [26:0] lpddr2_address;
    word_t       lpddr2_write_data;
    word_t       lpddr2_read_data;
    logic        lpddr2_rreq;
    logic        lpddr2_wreq;
    word_t       disk_hdin;
    word_t       disk_hdout;
    disk_addr_t  disk_hda;
    logic        disk_hd_w;
    word_t       debug_hex_display;

    word_t mem  [0:1023];  // Main memory, 4 KiB
    word_t disk [0:2047];
    word_t pat  [0:511];   // Program at 0, budget 256, count 257, write pairs from 258

    integer seed     = 32'h760b2f16;
    int     errors   = 0;
    int     wr_count = 0;
    int     exp_count;
    int     budget;
    bit     loaded   = 1'b0;
    bit     finished = 1'b0;

    cpu_master uut (
        .E(E), .jisr(jisr), .ena(ena),
        .lpddr2_address(lpddr2_address), .lpddr2_write_data(lpddr2_write_data),
        .lpddr2_read_data(lpddr2_read_data), .lpddr2_rreq(lpddr2_rreq),
        .lpddr2_wreq(lpddr2_wreq), .disk_hdin(disk_hdin), .disk_hdout(disk_hdout),
        .disk_hda(disk_hda), .disk_hd_w(disk_hd_w), .debug_hex_display(debug_hex_display)
    );

    bind cpu_master cpu_master_sva u_sva (
        .E(E), .jisr(jisr), .ena(ena), .phase(phase),
        .fetch_req(fetch_req), .data_req(data_req_en),
        .lpddr2_rreq(lpddr2_rreq), .lpddr2_wreq(lpddr2_wreq), .disk_hd_w(disk_hd_w)
    );

    always #4 E = ~E;  // 8 ns period

    // Same-cycle read data only while the read strobe is high, write on the edge
    assign lpddr2_read_data = lpddr2_rreq ? mem[lpddr2_address[9:0]] : 32'hffff_ffff;
    assign disk_hdout       = disk[disk_hda];

    always @(posedge E) begin
        if (lpddr2_wreq)
            mem[lpddr2_address[9:0]] <= lpddr2_write_data;
        if (disk_hd_w)
            disk[disk_hda] <= disk_hdin;
    end

    function automatic word_t fill_word(input int idx);
        word_t w;
        w = word_t'(idx);
        return (w * 32'h9e37_79b9) ^ 32'h5bd1_e995;
    endfunction

    task automatic check_equal(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s expected %08h actual %08h", name, expected, actual);
            $display("Errors found");
            $fatal(1, "Check failed: %s", name);
        end
    endtask

    task automatic abort_run(input string reason);
        errors++;
        $display("Run stopped: %s", reason);
        $display("Errors found");
        $fatal(1, "Simulation aborted");
    endtask

    task automatic check_write();
        addr_t got_addr;
        word_t got_data;
        if (lpddr2_wreq && disk_hd_w)
            abort_run("main memory and disk write strobes were raised together");
        if (wr_count >= exp_count)
            abort_run($sformatf("unexpected write, only %0d writes are listed", exp_count));
        if (disk_hd_w) begin
            got_addr = disk_base + {19'h0, disk_hda, 2'b00};
            got_data = disk_hdin;
        end else begin
            got_addr = {3'b000, lpddr2_address, 2'b00};
            got_data = lpddr2_write_data;
        end
        check_equal($sformatf("write %0d address", wr_count), pat[258 + 2 * wr_count], got_addr);
        check_equal($sformatf("write %0d data", wr_count), pat[259 + 2 * wr_count], got_data);
        wr_count++;
        if (disk_hd_w && disk_hda == 11'd2047)
            finished = 1'b1;  // Last disk word ends the program
    endtask

    // Strobes settle between the input change and the next edge
    always @(negedge E) begin
        if (!jisr && (lpddr2_wreq || disk_hd_w))
            check_write();
    end

    initial begin
        E    = 1'b0;
        jisr = 1'b1;
        ena  = 1'b0;
        for (int i = 0; i < 512; i++)
            pat[i] = '0;
        $readmemh("tb/program_patterns.hex", pat);
        budget    = int'(pat[256]);
        exp_count = int'(pat[257]);
        if (exp_count < 1 || exp_count > 100)
            abort_run("the pattern file holds an unusable write count");
        for (int i = 0; i < 1024; i++)
            mem[i] <= (i < 256) ? pat[i] : fill_word(i);
        for (int i = 0; i < 2048; i++)
            disk[i] <= ~fill_word(i);
        loaded = 1'b1;

        repeat (5) @(posedge E);
        #1 jisr = 1'b0;

        wait (finished);
        check_equal("write count", word_t'(exp_count), word_t'(wr_count));
        check_equal("final display", pat[258 + 2 * exp_count], debug_hex_display);
        if (errors == 0 && uut.u_sva.failures == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "Run ended with %0d errors", errors + uut.u_sva.failures);
        end
    end

    // Random stalls of one to four cycles
    initial begin : stall_driver
        int r;
        @(negedge jisr);
        forever begin
            @(posedge E);
            #1;
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                ena = 1'b0;
                repeat (r[5:4]) begin
                    @(posedge E);
                    #1;
                end
            end else begin
                ena = 1'b1;
            end
        end
    end

    initial begin : watchdog
        int limit_ns;
        wait (loaded);
        limit_ns = budget * 2 * 8 * 4 + 100 * 8;  // Stalls cost at most 4x
        #(limit_ns);
        abort_run($sformatf("timeout, the program did not finish within %0d ns", limit_ns));
    end

endmodule

/* tb/program_patterns.hex */
// Program words from @000, trap handler at @040 (byte 0x100)
// From @100: budget, write count, then one write per line as address data, then final r2
@000
3c011234 34215678 240a0400 2403fffd   // lui/ori r1, base r10, r3 = -3
24040005 00642821 00643023 3408ff0f   // r4 = 5, addu, subu, mask
00283824 00284825 0064582a 0083602a   // and, or, slt both ways
00046900 00037702 ad410000 ad450004   // sll, srl, first stores
ad460008 ad47000c ad490010 ad4b0014
ad4c0018 ad4d001c ad4e0020 8d4f0010   // lw back from 0x410
25ef0001 ad4f0024 3c108000 ae0f000c   // store to disk word 3
10a40001 ad440028 14a40001 ad43002c   // beq not taken, bne taken
08000022 ad430030 10a50001 ad430034   // j, beq taken
ad450038 fc000000 3c147fff 3694ffff   // illegal opcode at word 37
0284a820 ad55003c 22960001 ad560040   // add and addi overflow
00251021 ae021ffc 0800002e            // r2, disk word 2047, spin
@040
40117000 ad510100 42000018            // mfc0 r17, store EPC, eret
@100
00000040                              // instruction budget
00000013                              // expected writes
00000400 12345678
00000404 00000002
00000408 fffffff8
0000040c 00005608
00000410 1234ff7f
00000414 00000001
00000418 00000000
0000041c 00000050
00000420 0000000f
00000424 1234ff80
8000000c 1234ff80
00000428 00000005
00000438 00000002
00000500 00000098
00000500 000000a4
0000043c 00000000
00000500 000000ac
00000440 00000000
80001ffc 1234567a
1234567a                              // final debug display

/* build.f */
hw/cpu_pkg.sv
hw/cpu_gpr.sv
hw/mem_arbiter.sv
hw/cpu_sequencer.sv
hw/cpu_decode.sv
hw/cpu_execute.sv
hw/cpu_master.sv
tb/cpu_master_sva.sv
tb/cpu_master_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cpu_master_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Errors found
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
	    --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG) || [ $$status -ne 0 ]; then \
	    echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
